// File: dma_pkg.sv
/* DMA host shared definitions */

package dma_pkg;

    localparam int num_channels = 4;
    localparam int chan_w       = 2;
    localparam int max_beats    = 256;  // Cap per transfer
    localparam int burst_beats  = 16;
    localparam int addr_step    = 4;    // Bytes per beat

    typedef logic [31:0]       addr_t;
    typedef logic [15:0]       len_t;
    typedef logic [8:0]        count_t;  // 0 to 256
    typedef logic [chan_w-1:0] chan_t;

    // Command as written by software
    typedef struct packed {
        chan_t channel;
        addr_t src;
        addr_t dst;
        len_t  len;
    } dma_cmd_t;

    // Stored descriptor, length already clipped
    typedef struct packed {
        addr_t  src;
        addr_t  dst;
        count_t beats;
    } dma_desc_t;

    typedef struct packed {
        chan_t  channel;
        addr_t  src;
        addr_t  dst;
        count_t index;       // Beat number within transfer
        logic   burst_last;
    } dma_beat_t;

    typedef struct packed {
        chan_t  channel;
        count_t count;       // Beats completed
        logic   aborted;
    } dma_done_t;

    typedef enum logic [2:0] {
        idle,
        load,
        issue,
        wait_ack,
        finish
    } seq_state_t;

endpackage

// File: dma_cmd_intake.sv
/* DMA command intake */

module dma_cmd_intake
    import dma_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_req,
    input  dma_cmd_t  cmd,
    input  logic      abort,
    input  logic      desc_take,
    input  logic      seq_release,
    output logic      cmd_ack,
    output logic      cmd_ok,
    output logic      desc_valid,
    output chan_t     desc_chan,
    output dma_desc_t desc,
    output logic      any_pending
);

    dma_desc_t desc_tab [num_channels];
    logic [num_channels-1:0] pending_q;
    logic [num_channels-1:0] active_q;
    logic [num_channels-1:0] ready;
    logic decided_q;   // Command judged, ack follows next edge
    logic ok_q;
    logic cmd_new;
    logic accept;

    function automatic count_t clip_len(input len_t len);
        if (len > len_t'(max_beats)) begin
            return count_t'(max_beats);
        end
        return count_t'(len);
    endfunction

    assign cmd_new = cmd_req && !cmd_ack && !decided_q;
    assign accept  = cmd_new && !pending_q[cmd.channel] && !active_q[cmd.channel];

    // Four-phase slave side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            decided_q <= 1'b0;
            ok_q      <= 1'b0;
            cmd_ack   <= 1'b0;
            cmd_ok    <= 1'b0;
        end else begin
            if (cmd_new) begin
                decided_q <= 1'b1;
                ok_q      <= accept;
            end else if (decided_q && !cmd_ack) begin
                cmd_ack <= 1'b1;
                cmd_ok  <= ok_q;
            end else if (cmd_ack && !cmd_req) begin
                cmd_ack   <= 1'b0;
                cmd_ok    <= 1'b0;
                decided_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            desc_tab[cmd.channel] <= '{src: cmd.src, dst: cmd.dst, beats: clip_len(cmd.len)};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending_q <= '0;
            active_q  <= '0;
        end else begin
            if (abort) begin
                pending_q <= '0;                 // Drop every queued descriptor
            end else if (desc_take) begin
                pending_q[desc_chan] <= 1'b0;
            end
            if (accept) begin
                pending_q[cmd.channel] <= 1'b1;
            end
            if (desc_take) begin
                active_q[desc_chan] <= 1'b1;
            end else if (seq_release) begin
                active_q <= '0;                  // Only one channel runs at a time
            end
        end
    end

    assign ready = pending_q & ~active_q;

    // Lowest index wins
    always_comb begin
        desc_chan = '0;
        for (int i = num_channels - 1; i >= 0; i--) begin
            if (ready[i]) begin
                desc_chan = chan_t'(i);
            end
        end
    end

    assign desc_valid  = |ready;
    assign desc        = desc_tab[desc_chan];
    assign any_pending = |pending_q;

endmodule

// File: dma_burst_sequencer.sv
/* DMA burst sequencer */

module dma_burst_sequencer
    import dma_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      desc_valid,
    input  chan_t     desc_chan,
    input  dma_desc_t desc,
    input  logic      abort,
    input  logic      beat_fin,
    input  logic      done_fin,
    output logic      desc_take,
    output logic      seq_release,
    output logic      beat_go,
    output dma_beat_t beat,
    output logic      done_go,
    output dma_done_t done,
    output logic      active
);

    seq_state_t state_q;
    chan_t      chan_q;
    dma_desc_t  desc_q;
    addr_t      src_q;
    addr_t      dst_q;
    count_t     index_q;      // Beats completed so far
    count_t     index_next;
    logic       abort_req_q;
    logic       done_sent_q;
    logic       last_beat;
    logic       stop;
    logic       burst_end;

    assign index_next = index_q + count_t'(1);
    assign last_beat  = (index_next == desc_q.beats);
    assign stop       = abort_req_q || abort;
    assign burst_end  = (index_next % count_t'(burst_beats)) == '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= idle;
            index_q     <= '0;
            abort_req_q <= 1'b0;
            done_sent_q <= 1'b0;
        end else begin
            case (state_q)
                idle: begin
                    abort_req_q <= 1'b0;
                    done_sent_q <= 1'b0;
                    if (desc_take) begin
                        state_q <= load;
                    end
                end
                load: begin
                    index_q <= '0;
                    // Empty or already aborted transfers skip straight to report
                    if (desc_q.beats == '0 || stop) begin
                        state_q <= finish;
                    end else begin
                        state_q <= issue;
                    end
                end
                issue: state_q <= wait_ack;
                wait_ack: begin
                    if (beat_fin) begin
                        index_q <= index_next;
                        if (last_beat || stop) begin
                            state_q <= finish;
                        end else begin
                            state_q <= issue;
                        end
                    end
                end
                finish: begin
                    done_sent_q <= 1'b1;
                    if (done_fin) begin
                        state_q <= idle;
                    end
                end
                default: state_q <= idle;
            endcase

            // Held until the beat in flight completes
            if (abort && (state_q inside {load, issue, wait_ack})) begin
                abort_req_q <= 1'b1;
            end
        end
    end

    // Running addresses
    always_ff @(posedge clk) begin
        if (desc_take) begin
            chan_q <= desc_chan;
            desc_q <= desc;
        end
        if (state_q == load) begin
            src_q <= desc_q.src;
            dst_q <= desc_q.dst;
        end else if (state_q == wait_ack && beat_fin) begin
            src_q <= src_q + addr_t'(addr_step);
            dst_q <= dst_q + addr_t'(addr_step);
        end
    end

    assign desc_take   = (state_q == idle) && desc_valid && !abort;
    assign seq_release = (state_q == finish) && done_fin;
    assign beat_go     = (state_q == issue);
    assign done_go     = (state_q == finish) && !done_sent_q;  // One pulse per transfer
    assign active      = (state_q != idle);

    assign beat = '{
        channel:    chan_q,
        src:        src_q,
        dst:        dst_q,
        index:      index_q,
        burst_last: burst_end || last_beat
    };

    assign done = '{channel: chan_q, count: index_q, aborted: abort_req_q};

endmodule

// File: dma_transfer_port.sv
/* DMA beat and completion ports */

module dma_transfer_port
    import dma_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      beat_go,
    input  dma_beat_t beat,
    input  logic      beat_ack,
    input  logic      done_go,
    input  dma_done_t done,
    input  logic      done_ack,
    output logic      beat_req,
    output dma_beat_t beat_out,
    output logic      beat_fin,
    output logic      done_req,
    output dma_done_t done_out,
    output logic      done_fin,
    output logic      reporting
);

    logic beat_drop_q;   // Req dropped, waiting for ack low
    logic done_drop_q;

    // Beat master handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_req    <= 1'b0;
            beat_drop_q <= 1'b0;
            beat_fin    <= 1'b0;
        end else begin
            beat_fin <= 1'b0;
            if (beat_go) begin
                beat_req <= 1'b1;
            end else if (beat_req && beat_ack) begin
                beat_req    <= 1'b0;
                beat_drop_q <= 1'b1;
            end else if (beat_drop_q && !beat_ack) begin
                beat_drop_q <= 1'b0;
                beat_fin    <= 1'b1;
            end
        end
    end

    // Completion master handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_req    <= 1'b0;
            done_drop_q <= 1'b0;
            done_fin    <= 1'b0;
        end else begin
            done_fin <= 1'b0;
            if (done_go) begin
                done_req <= 1'b1;
            end else if (done_req && done_ack) begin
                done_req    <= 1'b0;
                done_drop_q <= 1'b1;
            end else if (done_drop_q && !done_ack) begin
                done_drop_q <= 1'b0;
                done_fin    <= 1'b1;
            end
        end
    end

    // Payloads held while req is up
    always_ff @(posedge clk) begin
        if (beat_go) begin
            beat_out <= beat;
        end
        if (done_go) begin
            done_out <= done;
        end
    end

    assign reporting = done_req || done_drop_q;

endmodule

// File: dma_host_top.sv
/* DMA transfer host */

module dma_host_top
    import dma_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_req,
    input  dma_cmd_t  cmd,
    input  logic      abort,
    input  logic      beat_ack,
    input  logic      done_ack,
    output logic      cmd_ack,
    output logic      cmd_ok,
    output logic      beat_req,
    output dma_beat_t beat_out,
    output logic      done_req,
    output dma_done_t done_out,
    output logic      busy
);

    logic      desc_valid;
    chan_t     desc_chan;
    dma_desc_t desc;
    logic      any_pending;
    logic      desc_take;
    logic      seq_release;
    logic      beat_go;
    dma_beat_t beat;
    logic      beat_fin;
    logic      done_go;
    dma_done_t done;
    logic      done_fin;
    logic      active;
    logic      reporting;

    dma_cmd_intake dma_cmd_intake_inst (
        .clk         (clk),
        .rst         (rst),
        .cmd_req     (cmd_req),
        .cmd         (cmd),
        .abort       (abort),
        .desc_take   (desc_take),
        .seq_release (seq_release),
        .cmd_ack     (cmd_ack),
        .cmd_ok      (cmd_ok),
        .desc_valid  (desc_valid),
        .desc_chan   (desc_chan),
        .desc        (desc),
        .any_pending (any_pending)
    );

    dma_burst_sequencer dma_burst_sequencer_inst (
        .clk         (clk),
        .rst         (rst),
        .desc_valid  (desc_valid),
        .desc_chan   (desc_chan),
        .desc        (desc),
        .abort       (abort),
        .beat_fin    (beat_fin),
        .done_fin    (done_fin),
        .desc_take   (desc_take),
        .seq_release (seq_release),
        .beat_go     (beat_go),
        .beat        (beat),
        .done_go     (done_go),
        .done        (done),
        .active      (active)
    );

    dma_transfer_port dma_transfer_port_inst (
        .clk       (clk),
        .rst       (rst),
        .beat_go   (beat_go),
        .beat      (beat),
        .beat_ack  (beat_ack),
        .done_go   (done_go),
        .done      (done),
        .done_ack  (done_ack),
        .beat_req  (beat_req),
        .beat_out  (beat_out),
        .beat_fin  (beat_fin),
        .done_req  (done_req),
        .done_out  (done_out),
        .done_fin  (done_fin),
        .reporting (reporting)
    );

    // Queue, transfer or report still outstanding
    assign busy = any_pending || active || reporting;

endmodule

// File: dma_clock_gen.sv
/* Testbench clock and reset */

module dma_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // Period 4
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk) rst = 1'b0;
    end

endmodule

// File: dma_host_properties.sv
/* Handshake assertions */

module dma_host_properties (
    input logic        clk,
    input logic        rst,
    input logic        req,
    input logic        ack,
    input logic [81:0] data
);

    // Req only falls once ack has been seen
    assert property (@(posedge clk) disable iff (rst) $fell(req) |-> (ack || $past(ack)))
        else $error("req fell before ack rose");

    assert property (@(posedge clk) disable iff (rst) (req && $past(req)) |-> $stable(data))
        else $error("payload changed while req was high");

    // Master may drop req half a cycle after ack rises
    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> (req || $past(req)))
        else $error("ack rose without req");

endmodule

bind dma_transfer_port dma_host_properties beat_props (
    .clk  (clk),
    .rst  (rst),
    .req  (beat_req),
    .ack  (beat_ack),
    .data ({6'b0, beat_out})
);

bind dma_transfer_port dma_host_properties done_props (
    .clk  (clk),
    .rst  (rst),
    .req  (done_req),
    .ack  (done_ack),
    .data ({70'b0, done_out})
);

bind dma_cmd_intake dma_host_properties cmd_props (
    .clk  (clk),
    .rst  (rst),
    .req  (cmd_req),
    .ack  (cmd_ack),
    .data (cmd)
);

// File: dma_host_tb.sv
/* DMA host testbench */

module dma_host_tb
    import dma_pkg::*;
();

    logic      clk;
    logic      rst;
    logic      cmd_req;
    dma_cmd_t  cmd;
    logic      abort;
    logic      beat_ack;
    logic      done_ack;
    logic      cmd_ack;
    logic      cmd_ok;
    logic      beat_req;
    dma_beat_t beat_out;
    logic      done_req;
    dma_done_t done_out;
    logic      busy;

    // op, chan, src, dst, len, expected ok, pad
    logic [95:0] pat [0:63];

    // Reference model, one slot per channel
    logic  mv [num_channels];
    addr_t m_src [num_channels];
    addr_t m_dst [num_channels];
    int    m_beats [num_channels];
    int    m_seen [num_channels];
    logic  m_abort [num_channels];

    logic [31:0] rng;
    int pass_cnt;
    int fail_cnt;
    int limit_cycles;

    dma_clock_gen clk_gen_inst (.clk(clk), .rst(rst));

    dma_host_top dma_host_top_inst (
        .clk      (clk),
        .rst      (rst),
        .cmd_req  (cmd_req),
        .cmd      (cmd),
        .abort    (abort),
        .beat_ack (beat_ack),
        .done_ack (done_ack),
        .cmd_ack  (cmd_ack),
        .cmd_ok   (cmd_ok),
        .beat_req (beat_req),
        .beat_out (beat_out),
        .done_req (done_req),
        .done_out (done_out),
        .busy     (busy)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic int lowest_valid();
        for (int i = 0; i < num_channels; i++) begin
            if (mv[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_cnt++;
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic report_error(input string msg);
        fail_cnt++;
        $display("Error: %s", msg);
    endtask

    task automatic check_beat();
        int ch;
        int idx;
        logic last;
        ch = int'(beat_out.channel);
        if (!mv[ch]) begin
            report_error($sformatf("beat on channel %0d with no live descriptor", ch));
        end else begin
            idx = m_seen[ch];
            if (idx == 0 && lowest_valid() != ch) begin
                report_error($sformatf("channel %0d started ahead of a lower channel", ch));
            end
            if (idx >= m_beats[ch]) begin
                report_error($sformatf("channel %0d issued more beats than requested", ch));
            end else begin
                last = ((idx + 1) % burst_beats == 0) || (idx + 1 == m_beats[ch]);
                compare("beat_out.index", 32'(beat_out.index), 32'(idx));
                compare("beat_out.src", beat_out.src, m_src[ch] + addr_t'(addr_step * idx));
                compare("beat_out.dst", beat_out.dst, m_dst[ch] + addr_t'(addr_step * idx));
                compare("beat_out.burst_last", 32'(beat_out.burst_last), 32'(last));
            end
            m_seen[ch]++;
        end
    endtask

    task automatic check_done();
        int ch;
        ch = int'(done_out.channel);
        if (!mv[ch]) begin
            report_error($sformatf("completion for channel %0d with no live descriptor", ch));
        end else begin
            compare("done_out.aborted", 32'(done_out.aborted), 32'(m_abort[ch]));
            compare("done_out.count", 32'(done_out.count), 32'(m_seen[ch]));
            if (!m_abort[ch] && m_seen[ch] != m_beats[ch]) begin
                report_error($sformatf("channel %0d ended with too few beats", ch));
            end
            if (int'(done_out.count) > m_beats[ch]) begin
                report_error($sformatf("channel %0d count above requested length", ch));
            end
            mv[ch]      = 1'b0;
            m_abort[ch] = 1'b0;
        end
    endtask

    // Memory agent
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && beat_req && !beat_ack) begin
                check_beat();
                rng = xorshift(rng);
                repeat (rng % 4) @(negedge clk);
                beat_ack = 1'b1;
                while (beat_req) @(negedge clk);
                beat_ack = 1'b0;
            end
        end
    end

    // Completion agent
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && done_req && !done_ack) begin
                check_done();
                rng = xorshift(rng);
                repeat (rng % 4) @(negedge clk);
                done_ack = 1'b1;
                while (done_req) @(negedge clk);
                done_ack = 1'b0;
            end
        end
    end

    task automatic send_command(input int ch, input addr_t s, input addr_t d,
                                input len_t len, input logic exp_ok);
        @(negedge clk);
        cmd     = '{channel: chan_t'(ch), src: s, dst: d, len: len};
        cmd_req = 1'b1;
        while (!cmd_ack) @(negedge clk);
        compare("cmd_ok", 32'(cmd_ok), 32'(exp_ok));
        if (exp_ok && !mv[ch]) begin
            mv[ch]      = 1'b1;
            m_src[ch]   = s;
            m_dst[ch]   = d;
            m_beats[ch] = (int'(len) > max_beats) ? max_beats : int'(len);
            m_seen[ch]  = 0;
            m_abort[ch] = 1'b0;
            compare("busy", 32'(busy), 32'd1);
        end
        cmd_req = 1'b0;
        while (cmd_ack) @(negedge clk);
    endtask

    task automatic send_abort();
        int cur;
        @(negedge clk);
        while (!beat_req) @(negedge clk);   // Abort in the middle of a transfer
        cur = int'(beat_out.channel);
        for (int i = 0; i < num_channels; i++) begin
            if (i == cur) begin
                m_abort[i] = 1'b1;
            end else begin
                mv[i] = 1'b0;
            end
        end
        abort = 1'b1;
        @(negedge clk);
        abort = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        while (lowest_valid() >= 0) @(negedge clk);
        n = 0;
        while (busy && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            report_error("busy stayed high after the queue drained");
        end else begin
            pass_cnt++;
        end
    endtask

    initial begin
        int total_beats;
        int op;
        cmd_req  = 1'b0;
        cmd      = '0;
        abort    = 1'b0;
        beat_ack = 1'b0;
        done_ack = 1'b0;
        rng      = 32'd72763;
        pass_cnt = 0;
        fail_cnt = 0;
        for (int i = 0; i < num_channels; i++) begin
            mv[i]      = 1'b0;
            m_abort[i] = 1'b0;
        end
        for (int i = 0; i < 64; i++) begin
            pat[i] = '0;
        end
        $readmemh("dma_host_patterns.hex", pat);

        // Watchdog budget from the beats the patterns ask for
        total_beats = 0;
        for (int i = 0; i < 64; i++) begin
            if (pat[i][95:92] == 4'h1 && pat[i][7:4] == 4'h1) begin
                total_beats += (int'(pat[i][23:8]) > max_beats) ? max_beats : int'(pat[i][23:8]);
            end
        end
        limit_cycles = total_beats * 12 + 2000;

        @(negedge clk);
        while (rst) @(negedge clk);
        compare("cmd_ack", 32'(cmd_ack), 32'd0);
        compare("cmd_ok", 32'(cmd_ok), 32'd0);
        compare("beat_req", 32'(beat_req), 32'd0);
        compare("done_req", 32'(done_req), 32'd0);
        compare("busy", 32'(busy), 32'd0);

        for (int i = 0; i < 64; i++) begin
            op = int'(pat[i][95:92]);
            if (op == 0) begin
                break;
            end
            case (op)
                1: send_command(int'(pat[i][91:88]), pat[i][87:56], pat[i][55:24],
                                pat[i][23:8], pat[i][4]);
                2: send_abort();
                default: wait_idle();
            endcase
            $display("test %0d op %0d finished, failures so far %0d", i, op, fail_cnt);
        end

        $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #1;
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, run did not complete", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: dma_host_patterns.hex
// op chan src dst len ok pad
// op 1 command, 2 abort, 3 wait idle
1_0_00001000_00002000_0005_1_0
3_0_00000000_00000000_0000_0_0
1_1_00010000_00020000_0020_1_0
1_2_00030000_00040000_0000_1_0
3_0_00000000_00000000_0000_0_0
1_3_00100000_00200000_0028_1_0
1_2_00110000_00210000_0003_1_0
1_1_00120000_00220000_0002_1_0
1_0_00130000_00230000_0001_1_0
1_2_00500000_00600000_0004_0_0
1_3_00500000_00600000_0004_0_0
3_0_00000000_00000000_0000_0_0
1_1_00400000_00800000_0300_1_0
3_0_00000000_00000000_0000_0_0
1_2_01000000_02000000_0064_1_0
1_0_01100000_02100000_000A_1_0
1_1_01200000_02200000_000A_1_0
2_0_00000000_00000000_0000_0_0
3_0_00000000_00000000_0000_0_0
1_0_03000000_04000000_0003_1_0
3_0_00000000_00000000_0000_0_0

// File: project.f
dma_pkg.sv
dma_cmd_intake.sv
dma_burst_sequencer.sv
dma_transfer_port.sv
dma_host_top.sv
dma_clock_gen.sv
dma_host_properties.sv
dma_host_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = dma_host_tb
FILELIST  = project.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJDIR)
